// File: Bender.yml
package:
  name: msx_upload

sources:
  - include_dirs:
      - common
    files:
      - common/upload_pkg.sv
      - slot_map/slot_layout_table.sv
      - rtl/ram_fill.sv
      - rtl/upload_ctrl.sv
      - rtl/upload_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/upload_model.sv
      - verif/upload_tb.sv

// File: common/upload_cfg.svh
`ifndef UPLOAD_CFG_SVH
`define UPLOAD_CFG_SVH

// DDR3 byte address and RAM address widths
`define UPLOAD_DDR_AW       28
`define UPLOAD_RAM_AW       27
`define UPLOAD_SIZE_W       27

// Image records
`define UPLOAD_REC_BYTES    16
`define UPLOAD_SIG0         "M"
`define UPLOAD_SIG1         "S"
`define UPLOAD_SIG2         "X"

// Table depths
`define UPLOAD_SLOT_BLOCKS  64   // 4 slots x 4 subslots x 4 blocks
`define UPLOAD_RAM_REFS     16

// Region sizes count in 16 KB units
`define UPLOAD_UNIT_SHIFT   14
`define UPLOAD_PAT_SPAN_W   9

`endif

// File: common/upload_pkg.sv
`include "upload_cfg.svh"

package upload_pkg;

   typedef enum logic [3:0] {
      CONFIG_NONE, CONFIG_FW, CONFIG_SLOT_A, CONFIG_SLOT_B,
      CONFIG_SLOT_INTERNAL, CONFIG_IO_DEVICE, CONFIG_CONFIG, CONFIG_KBD_LAYOUT
   } config_typ_t;

   typedef enum logic [7:0] {
      MAPPER_NONE, MAPPER_ASCII8, MAPPER_ASCII16, MAPPER_KONAMI, MAPPER_KONAMI_SCC,
      MAPPER_RAM, MAPPER_FMPAC, MAPPER_GM2, MAPPER_UNUSED
   } mapper_typ_t;

   typedef enum logic [7:0] {
      DEVICE_NONE, DEVICE_FDC, DEVICE_MFRSD0
   } device_typ_t;

   typedef enum logic [7:0] {
      ROM_NONE, ROM_ROM, ROM_RAM, ROM_FDC, ROM_FMPAC, ROM_MFRSD, ROM_GM2
   } data_id_t;

   typedef enum logic [1:0] {MSX1, MSX2, MSX2P, MSXTR} msx_typ_t;

   typedef enum logic [2:0] {
      PAT_COPY, PAT_FF, PAT_00, PAT_CHECK_A, PAT_CHECK_B, PAT_HALF
   } fill_pat_t;

   typedef struct packed {
      logic  [3:0] slot_subslot;
      data_id_t    data_id;
      device_typ_t device;
      mapper_typ_t mapper;
      logic  [7:0] mode;      // 2 bits per block
      logic  [7:0] param;
      logic [10:0] units;     // 16 KB units
      fill_pat_t   pattern;
   } slot_record_t;

   typedef struct packed {
      logic [`UPLOAD_RAM_AW-1:0] addr;
      logic               [15:0] size;
      logic                      ro;
   } lookup_ram_t;

   typedef struct packed {
      mapper_typ_t mapper;
      device_typ_t device;
      logic  [3:0] ref_ram;
      logic  [1:0] offset_ram;   // 16 KB page inside the region
   } block_t;

   typedef struct packed {
      logic  [7:0] ram_size;
      logic        use_fdc;
      msx_typ_t    msx_typ;
      logic  [3:0] slot_expander_en;
   } bios_config_t;

   typedef struct packed {
      logic [10:0] units;
      fill_pat_t   pattern;
      data_id_t    data_id;
   } fill_req_t;

endpackage

// File: msx_upload.f
+incdir+common
common/upload_pkg.sv
slot_map/slot_layout_table.sv
rtl/ram_fill.sv
rtl/upload_ctrl.sv
rtl/upload_top.sv
verif/upload_model.sv
verif/upload_tb.sv

// File: rtl/ram_fill.sv
`timescale 1ns/1ns
`include "upload_cfg.svh"

module ram_fill (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          walk_start,
   input  logic                          fill_start,
   input  upload_pkg::fill_req_t         fill_req,
   input  logic                          src_valid,
   input  logic                    [7:0] src_byte,
   input  logic                          sdram_ready,
   output logic                          src_req,
   output logic     [`UPLOAD_RAM_AW-1:0] ram_addr,
   output logic                    [7:0] ram_din,
   output logic                          ram_ce,
   output logic                          fill_done,
   output logic                    [3:0] fill_ref,
   output upload_pkg::lookup_ram_t       lookup_ram [`UPLOAD_RAM_REFS]
);
   import upload_pkg::*;

   logic                                busy;
   logic                                copy;
   fill_pat_t                           pattern;
   logic [`UPLOAD_UNIT_SHIFT+10:0]      left;       // Bytes still to write
   logic [`UPLOAD_PAT_SPAN_W-1:0]       pos;        // Offset from region start
   logic                                buf_full;
   logic                          [7:0] buf_byte;
   logic                          [3:0] next_ref;
   logic                          [7:0] pat_byte;
   logic                                wr_go;

   always_comb begin
      case (pattern)
         PAT_00:      pat_byte = 8'h00;
         PAT_CHECK_A: pat_byte = {8{pos[8] == pos[1]}};
         PAT_CHECK_B: pat_byte = {8{pos[8] != pos[0]}};
         PAT_HALF:    pat_byte = {8{pos[7]}};
         default:     pat_byte = 8'hff;
      endcase
   end

   assign src_req = busy & copy & ~buf_full;
   assign wr_go   = busy & (buf_full | ~copy) & sdram_ready & ~ram_ce;

   always_ff @(posedge clk) begin
      fill_done <= 1'b0;
      if (ram_ce) begin
         ram_ce   <= 1'b0;
         ram_addr <= ram_addr + 1'b1;
      end
      if (src_valid) begin
         buf_byte <= src_byte;
         buf_full <= 1'b1;
      end
      if (fill_start) begin
         lookup_ram[next_ref] <= '{addr: ram_addr, size: 16'(fill_req.units),
                                   ro: fill_req.data_id != ROM_RAM};
         fill_ref <= next_ref;
         next_ref <= next_ref + 1'b1;
         copy     <= fill_req.data_id != ROM_RAM;
         pattern  <= fill_req.pattern;
         left     <= {fill_req.units, {`UPLOAD_UNIT_SHIFT{1'b0}}};
         pos      <= '0;
         busy     <= 1'b1;
      end
      if (wr_go) begin
         ram_ce   <= 1'b1;
         ram_din  <= copy ? buf_byte : pat_byte;
         buf_full <= 1'b0;
         left     <= left - 1'b1;
         pos      <= pos + 1'b1;
         if (left == 1) begin
            busy      <= 1'b0;
            fill_done <= 1'b1;
         end
      end
      if (walk_start) begin   // New image starts at RAM address 0
         ram_addr <= '0;
         next_ref <= '0;
         busy     <= 1'b0;
         buf_full <= 1'b0;
      end
      if (reset) begin
         busy      <= 1'b0;
         buf_full  <= 1'b0;
         ram_ce    <= 1'b0;
         fill_done <= 1'b0;
      end
   end

   // An unrequested byte would overwrite the one in the buffer
   a_src_requested: assert property (@(posedge clk) disable iff (reset)
      src_valid |-> src_req);

endmodule

// File: rtl/upload_ctrl.sv
`timescale 1ns/1ns
`include "upload_cfg.svh"

module upload_ctrl (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          ioctl_download,
   input  logic                   [15:0] ioctl_index,
   input  logic     [`UPLOAD_SIZE_W-1:0] ioctl_addr,
   input  logic                          reload,
   output logic                          reset_rq,
   output logic     [`UPLOAD_DDR_AW-1:0] ddr3_addr,
   output logic                          ddr3_rd,
   output logic                          ddr3_request,
   input  logic                    [7:0] ddr3_dout,
   input  logic                          ddr3_ready,
   input  logic                          src_req,
   output logic                          src_valid,
   output logic                    [7:0] src_byte,
   output logic                          fill_start,
   output upload_pkg::fill_req_t         fill_req,
   input  logic                          fill_done,
   input  logic                    [3:0] fill_ref,
   output logic                          slot_clear,
   input  logic                          slot_clear_done,
   output logic                          slot_store,
   output upload_pkg::slot_record_t      slot_rec,
   output logic                    [3:0] store_ref,
   output upload_pkg::bios_config_t      bios_config
);
   import upload_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE, ST_CLEAR, ST_NEXT, ST_READ, ST_DECODE, ST_FILL, ST_STORE
   } state_t;

   state_t                    state;
   logic [`UPLOAD_SIZE_W-1:0] image_size;
   logic                      download_q;
   logic                      pending;    // Read accepted, byte not taken yet
   logic                [3:0] byte_cnt;
   logic                [7:0] rec [`UPLOAD_REC_BYTES];
   logic                      dl_end;
   logic                      load;
   logic                      rd_take;
   logic                      byte_ok;
   logic                      sig_ok;
   config_typ_t               rec_typ;

   assign dl_end  = download_q & ~ioctl_download & (ioctl_index[5:0] == 6'd1);
   assign load    = dl_end | reload;
   assign rd_take = ddr3_rd & ddr3_ready;
   assign byte_ok = pending & ddr3_ready & ~ddr3_rd;
   assign sig_ok  = rec[0] == `UPLOAD_SIG0 && rec[1] == `UPLOAD_SIG1 && rec[2] == `UPLOAD_SIG2;
   assign rec_typ = config_typ_t'(rec[3][7:4]);

   assign slot_rec = '{slot_subslot: rec[3][3:0],
                       data_id:      data_id_t'(rec[4]),
                       device:       device_typ_t'(rec[7]),
                       mapper:       mapper_typ_t'(rec[8]),
                       mode:         rec[9],
                       param:        rec[10],
                       units:        {rec[5][2:0], rec[6]},
                       pattern:      fill_pat_t'(rec[11][2:0])};
   assign fill_req = '{units: slot_rec.units, pattern: slot_rec.pattern, data_id: slot_rec.data_id};

   assign reset_rq   = state != ST_IDLE;
   assign slot_store = state == ST_STORE;
   assign src_valid  = (state == ST_FILL) & byte_ok;   // Copy data follows the record
   assign src_byte   = ddr3_dout;

   always_ff @(posedge clk) begin
      download_q <= ioctl_download;
      fill_start <= 1'b0;
      slot_clear <= 1'b0;
      if (dl_end) image_size <= ioctl_addr;
      if (rd_take) begin
         ddr3_rd   <= 1'b0;
         ddr3_addr <= ddr3_addr + 1'b1;
         pending   <= 1'b1;
      end
      if (byte_ok) pending <= 1'b0;
      case (state)
         ST_CLEAR: if (slot_clear_done) state <= ST_NEXT;
         ST_NEXT: begin
            byte_cnt <= '0;
            if (ddr3_addr >= image_size) begin
               state        <= ST_IDLE;
               ddr3_request <= 1'b0;
            end else if (ddr3_ready) begin
               ddr3_rd <= 1'b1;
               state   <= ST_READ;
            end
         end
         ST_READ: if (byte_ok) begin
            rec[byte_cnt] <= ddr3_dout;
            byte_cnt      <= byte_cnt + 1'b1;
            if (byte_cnt == 4'(`UPLOAD_REC_BYTES - 1)) state <= ST_DECODE;
            else ddr3_rd <= 1'b1;
         end
         ST_DECODE: begin
            state <= ST_NEXT;   // Bad signature or unknown type
            if (sig_ok && rec_typ == CONFIG_CONFIG) begin
               bios_config.msx_typ          <= msx_typ_t'(rec[4][5:4]);
               bios_config.slot_expander_en <= rec[4][3:0];
            end
            if (sig_ok && rec_typ == CONFIG_SLOT_INTERNAL) begin
               if (slot_rec.device == DEVICE_FDC) bios_config.use_fdc <= 1'b1;
               if (slot_rec.data_id == ROM_RAM && bios_config.ram_size < rec[6])
                  bios_config.ram_size <= rec[6];
               store_ref <= '0;
               state     <= ST_STORE;
               if (slot_rec.units != '0) begin
                  fill_start <= 1'b1;
                  state      <= ST_FILL;
               end
            end
         end
         ST_FILL: begin
            if (src_req && ddr3_ready && !pending && !ddr3_rd) ddr3_rd <= 1'b1;
            if (fill_done) begin
               store_ref <= fill_ref;
               state     <= ST_STORE;
            end
         end
         ST_STORE: state <= ST_NEXT;
         default: ;
      endcase
      if (load) begin
         state        <= ST_CLEAR;
         slot_clear   <= 1'b1;
         ddr3_request <= 1'b1;
         ddr3_addr    <= '0;
         ddr3_rd      <= 1'b0;
         pending      <= 1'b0;
         bios_config  <= '0;
      end
      if (reset) begin
         state        <= ST_IDLE;
         download_q   <= 1'b0;
         ddr3_rd      <= 1'b0;
         pending      <= 1'b0;
         ddr3_request <= 1'b0;
         fill_start   <= 1'b0;
         slot_clear   <= 1'b0;
      end
   end

   a_rd_needs_ready: assert property (@(posedge clk) disable iff (reset)
      !ddr3_rd && !ddr3_ready |=> !ddr3_rd);

endmodule

// File: rtl/upload_top.sv
`timescale 1ns/1ns
`include "upload_cfg.svh"

module upload_top (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          ioctl_download,
   input  logic                   [15:0] ioctl_index,
   input  logic     [`UPLOAD_SIZE_W-1:0] ioctl_addr,
   input  logic                          reload,
   output logic                          reset_rq,
   output logic     [`UPLOAD_DDR_AW-1:0] ddr3_addr,
   output logic                          ddr3_rd,
   output logic                          ddr3_request,
   input  logic                    [7:0] ddr3_dout,
   input  logic                          ddr3_ready,
   output logic     [`UPLOAD_RAM_AW-1:0] ram_addr,
   output logic                    [7:0] ram_din,
   output logic                          ram_ce,
   input  logic                          sdram_ready,
   output upload_pkg::lookup_ram_t       lookup_ram [`UPLOAD_RAM_REFS],
   output upload_pkg::block_t            slot_layout [`UPLOAD_SLOT_BLOCKS],
   output upload_pkg::bios_config_t      bios_config
);
   import upload_pkg::*;

   logic         src_req;
   logic         src_valid;
   logic   [7:0] src_byte;
   logic         fill_start;
   fill_req_t    fill_req;
   logic         fill_done;
   logic   [3:0] fill_ref;
   logic         slot_clear;        // Also restarts RAM allocation
   logic         slot_clear_done;
   logic         slot_store;
   slot_record_t slot_rec;
   logic   [3:0] store_ref;

   upload_ctrl u_upload_ctrl (.*);

   ram_fill u_ram_fill (
      .walk_start(slot_clear),
      .*
   );

   slot_layout_table u_slot_layout_table (.*);

endmodule

// File: slot_map/slot_layout_table.sv
`timescale 1ns/1ns
`include "upload_cfg.svh"

module slot_layout_table (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     slot_clear,
   input  logic                     slot_store,
   input  upload_pkg::slot_record_t slot_rec,
   input  logic               [3:0] store_ref,
   output logic                     slot_clear_done,
   output upload_pkg::block_t       slot_layout [`UPLOAD_SLOT_BLOCKS]
);
   import upload_pkg::*;

   logic       clearing;
   logic [5:0] idx;
   logic [3:0] blk_ref;

   // Regions without data get ref 0
   assign blk_ref = (slot_rec.data_id == ROM_NONE) ? 4'd0 : store_ref;

   always_ff @(posedge clk) begin
      logic [1:0] m;
      logic [1:0] p;
      block_t     src;
      slot_clear_done <= 1'b0;
      if (clearing) begin
         slot_layout[idx].mapper <= MAPPER_UNUSED;
         slot_layout[idx].device <= DEVICE_NONE;
         idx <= idx + 1'b1;
         if (idx == 6'(`UPLOAD_SLOT_BLOCKS - 1)) begin
            clearing        <= 1'b0;
            slot_clear_done <= 1'b1;
         end
      end
      if (slot_clear) begin
         clearing <= 1'b1;
         idx      <= '0;
      end
      if (slot_store) begin
         for (int b = 0; b < 4; b++) begin
            m   = slot_rec.mode[2*b +: 2];
            p   = slot_rec.param[2*b +: 2];
            src = slot_layout[{slot_rec.slot_subslot, p}];   // Mirror source
            case (m)
               2'd1: slot_layout[{slot_rec.slot_subslot, 2'(b)}] <=
                  '{mapper: src.mapper, device: DEVICE_NONE,
                    ref_ram: src.ref_ram, offset_ram: src.offset_ram};
               2'd2, 2'd3: slot_layout[{slot_rec.slot_subslot, 2'(b)}] <=
                  '{mapper: (m == 2'd2) ? slot_rec.mapper : MAPPER_UNUSED,
                    device: slot_rec.device, ref_ram: blk_ref, offset_ram: p};
               default: ;
            endcase
         end
      end
      if (reset) begin
         clearing        <= 1'b0;
         slot_clear_done <= 1'b0;
      end
   end

   a_no_store_in_clear: assert property (@(posedge clk) disable iff (reset)
      slot_store |-> !clearing);

endmodule

// File: verif/upload_model.sv
`include "upload_cfg.svh"

package upload_model;
   import upload_pkg::*;

   localparam int unit_bytes = 1 << `UPLOAD_UNIT_SHIFT;

   typedef struct packed {
      logic   [2:0] kind;      // 0 config, 1 to 3 region, 4 bad signature, 5 unknown type
      slot_record_t slot;
      logic   [7:0] cfg;       // Byte 4 of a config record
      logic  [31:0] data_at;   // Image offset of copy data
   } entry_t;

   entry_t       entries [$];
   logic   [7:0] image [$];
   logic   [7:0] exp_ram [int];
   lookup_ram_t  exp_lookup [`UPLOAD_RAM_REFS];
   block_t       exp_layout [`UPLOAD_SLOT_BLOCKS];   // Kept across walks like the table
   bios_config_t exp_bios;
   int           exp_refs;

   function automatic logic is_region(entry_t e);
      return e.kind >= 1 && e.kind <= 3;
   endfunction

   function automatic void build_image();
      entry_t     e;
      logic [3:0] typ;
      int         n;
      entries.delete();
      image.delete();
      n = 3 + $urandom_range(3);
      for (int r = 0; r < n; r++) begin
         e.kind              = 3'($urandom_range(5));
         e.slot.slot_subslot = 4'($urandom);
         e.slot.data_id      = data_id_t'($urandom_range(6));
         e.slot.device       = device_typ_t'($urandom_range(2));
         e.slot.mapper       = mapper_typ_t'($urandom_range(8));
         e.slot.mode         = 8'($urandom);
         e.slot.param        = 8'($urandom);
         e.slot.units        = 11'(1 + $urandom_range(1));
         e.slot.pattern      = fill_pat_t'($urandom_range(5));
         e.cfg               = 8'($urandom);
         typ = CONFIG_SLOT_INTERNAL;
         if (e.kind == 0) typ = CONFIG_CONFIG;
         if (e.kind == 5) typ = 4'($urandom_range(15, 8));
         image.push_back(`UPLOAD_SIG0);
         image.push_back(`UPLOAD_SIG1);
         image.push_back((e.kind == 4) ? "Y" : `UPLOAD_SIG2);
         image.push_back({typ, e.slot.slot_subslot});
         image.push_back((e.kind == 0) ? e.cfg : 8'(e.slot.data_id));
         image.push_back({5'd0, e.slot.units[10:8]});
         image.push_back(e.slot.units[7:0]);
         image.push_back(8'(e.slot.device));
         image.push_back(8'(e.slot.mapper));
         image.push_back(e.slot.mode);
         image.push_back(e.slot.param);
         image.push_back({5'd0, 3'(e.slot.pattern)});
         repeat (4) image.push_back(8'($urandom));   // Unused tail of the record
         e.data_at = image.size();
         if (is_region(e) && e.slot.data_id != ROM_RAM)
            repeat (e.slot.units * unit_bytes) image.push_back(8'($urandom));
         entries.push_back(e);
      end
   endfunction

   function automatic logic [7:0] fill_byte(fill_pat_t pat, int offset);
      logic [8:0] q;
      q = 9'(offset);
      case (pat)
         PAT_00:      return 8'h00;
         PAT_CHECK_A: return (q[8] == q[1]) ? 8'hff : 8'h00;
         PAT_CHECK_B: return (q[8] != q[0]) ? 8'hff : 8'h00;
         PAT_HALF:    return q[7] ? 8'hff : 8'h00;
         default:     return 8'hff;
      endcase
   endfunction

   function automatic void store_blocks(slot_record_t s, logic [3:0] ref_id);
      block_t     old [4];
      int         base;
      logic [1:0] m;
      logic [1:0] p;
      base = s.slot_subslot * 4;
      for (int b = 0; b < 4; b++) old[b] = exp_layout[base + b];
      for (int b = 0; b < 4; b++) begin
         m = s.mode[2*b +: 2];
         p = s.param[2*b +: 2];
         if (m == 2'd1) begin
            exp_layout[base + b]        = old[p];   // Mirror of a sibling block
            exp_layout[base + b].device = DEVICE_NONE;
         end else if (m != 2'd0) begin
            exp_layout[base + b].mapper     = (m == 2'd2) ? s.mapper : MAPPER_UNUSED;
            exp_layout[base + b].device     = s.device;
            exp_layout[base + b].ref_ram    = (s.data_id == ROM_NONE) ? 4'd0 : ref_id;
            exp_layout[base + b].offset_ram = p;
         end
      end
   endfunction

   function automatic void run_model();
      int           ram_at;
      logic   [3:0] ref_id;
      slot_record_t s;
      ram_at   = 0;
      exp_refs = 0;
      exp_bios = '0;
      exp_ram.delete();
      foreach (exp_layout[i]) begin
         exp_layout[i].mapper = MAPPER_UNUSED;
         exp_layout[i].device = DEVICE_NONE;
      end
      foreach (entries[i]) begin
         s = entries[i].slot;
         if (entries[i].kind == 0) begin
            exp_bios.msx_typ          = msx_typ_t'(entries[i].cfg[5:4]);
            exp_bios.slot_expander_en = entries[i].cfg[3:0];
         end
         if (is_region(entries[i])) begin
            if (s.device == DEVICE_FDC) exp_bios.use_fdc = 1'b1;
            if (s.data_id == ROM_RAM && s.units[7:0] > exp_bios.ram_size)
               exp_bios.ram_size = s.units[7:0];
            ref_id = 4'd0;
            if (s.units != 0) begin
               ref_id = 4'(exp_refs);
               exp_lookup[exp_refs] = '{addr: `UPLOAD_RAM_AW'(ram_at), size: 16'(s.units),
                                        ro: s.data_id != ROM_RAM};
               exp_refs++;
               for (int a = 0; a < s.units * unit_bytes; a++)
                  exp_ram[ram_at + a] = (s.data_id == ROM_RAM) ? fill_byte(s.pattern, a)
                                                               : image[entries[i].data_at + a];
               ram_at += s.units * unit_bytes;
            end
            store_blocks(s, ref_id);
         end
      end
   endfunction

endpackage

// File: verif/upload_tb.sv
`timescale 1ns/1ns
`include "upload_cfg.svh"

module upload_tb;
   import upload_pkg::*;
   import upload_model::*;

   localparam int rise_limit = 8;
   localparam int walk_limit = 4_000_000;   // Cycles for a whole walk

   logic                      clk = 1'b0;
   logic                      reset;
   logic                      ioctl_download;
   logic               [15:0] ioctl_index;
   logic [`UPLOAD_SIZE_W-1:0] ioctl_addr;
   logic                      reload;
   logic                      reset_rq;
   logic [`UPLOAD_DDR_AW-1:0] ddr3_addr;
   logic                      ddr3_rd;
   logic                      ddr3_request;
   logic                [7:0] ddr3_dout;
   logic                      ddr3_ready;
   logic [`UPLOAD_RAM_AW-1:0] ram_addr;
   logic                [7:0] ram_din;
   logic                      ram_ce;
   logic                      sdram_ready;
   lookup_ram_t               lookup_ram [`UPLOAD_RAM_REFS];
   block_t                    slot_layout [`UPLOAD_SLOT_BLOCKS];
   bios_config_t              bios_config;
   bit                        seen [int];   // RAM bytes written in this walk

   upload_top u_upload_top (.*);

   always #10 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input logic [`UPLOAD_RAM_AW-1:0] addr, input logic [7:0] got,
                             input logic [7:0] exp);
      if (got !== exp)
         fail_run($sformatf("FAILED ram_din[%h]: got %h expected %h", addr, got, exp));
   endtask

   task automatic check_lookup(input int idx, input lookup_ram_t got, input lookup_ram_t exp);
      if (got !== exp)
         fail_run($sformatf("FAILED lookup_ram[%0d]: got %h expected %h", idx, got, exp));
   endtask

   task automatic check_block(input int idx, input block_t got, input block_t exp);
      if (got !== exp)
         fail_run($sformatf("FAILED slot_layout[%0d]: got %h expected %h", idx, got, exp));
   endtask

   task automatic check_bios(input bios_config_t got, input bios_config_t exp);
      if (got !== exp)
         fail_run($sformatf("FAILED bios_config: got %h expected %h", got, exp));
   endtask

   // Memory side, outputs sampled before new inputs are driven
   always @(negedge clk) begin
      if (ram_ce === 1'b1) begin
         if (!sdram_ready) begin
            fail_run("RAM write issued while sdram_ready was low");
         end else if (!exp_ram.exists(ram_addr) || seen.exists(ram_addr)) begin
            fail_run($sformatf("RAM write to %h is outside the regions or repeated", ram_addr));
         end else begin
            check_byte(ram_addr, ram_din, exp_ram[ram_addr]);
            seen[ram_addr] = 1'b1;
         end
      end
      ddr3_ready  = $urandom_range(3) != 0;   // Random gaps
      sdram_ready = $urandom_range(3) != 0;
      if (!$isunknown(ddr3_addr) && ddr3_addr != 0 && ddr3_addr <= image.size())
         ddr3_dout = image[ddr3_addr - 1];   // Byte of the last accepted read
   end

   task automatic wait_reset_rq(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (reset_rq !== level) begin
         if (n == limit) fail_run(what);
         n++;
         @(negedge clk);
      end
   endtask

   task automatic verify_walk();
      if (ddr3_request !== 1'b0) fail_run("ddr3_request stayed high after the walk");
      if (seen.num() != exp_ram.num())
         fail_run($sformatf("only %0d of %0d RAM bytes were written", seen.num(), exp_ram.num()));
      check_bios(bios_config, exp_bios);
      for (int i = 0; i < exp_refs; i++) check_lookup(i, lookup_ram[i], exp_lookup[i]);
      foreach (slot_layout[i]) check_block(i, slot_layout[i], exp_layout[i]);
   endtask

   task automatic run_walk(input string source);
      wait_reset_rq(1'b1, rise_limit, {"reset_rq did not rise after the ", source});
      wait_reset_rq(1'b0, walk_limit, {"reset_rq did not fall at the end of the ", source, " walk"});
      verify_walk();
   endtask

   initial begin
      void'($urandom(32'hc6996375));
      reset          = 1'b1;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      reload         = 1'b0;
      ddr3_dout      = '0;
      ddr3_ready     = 1'b0;
      sdram_ready    = 1'b0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      if (reset_rq !== 1'b0 || ddr3_rd !== 1'b0 || ram_ce !== 1'b0)
         fail_run("reset_rq, ddr3_rd or ram_ce not low after reset");
      build_image();
      run_model();
      ioctl_index    = 16'd1;
      ioctl_addr     = `UPLOAD_SIZE_W'(image.size());
      ioctl_download = 1'b1;
      repeat (4) @(negedge clk);
      ioctl_download = 1'b0;
      run_walk("download");
      seen.delete();
      run_model();   // Same image again
      reload = 1'b1;
      @(negedge clk);
      reload = 1'b0;
      run_walk("reload");
      $display("STATUS: PASS");
      $finish;
   end

endmodule
